//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= qspi_pgm_tb
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed (exit $$status)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+design
design/qspi_pgm_pkg.sv
design/vir_decode.sv
design/scan_regs.sv
design/opcode_sequencer.sv
design/qspi_pgm_top.sv
verification/tb_clock.sv
verification/qspi_pgm_assert.sv
verification/qspi_pgm_tb.sv

//--- design/opcode_sequencer.sv
`timescale 1ns/10ps
`include "qspi_pgm_config.svh"

module opcode_sequencer (
	input  logic                     tck,
	input  logic                     rst_n,
	input  logic                     sdr,
	input  qspi_pgm_pkg::vir_cmd_t   cmd,
	input  logic                     opcode_bit,
	input  qspi_pgm_pkg::io1_mode_e  io1_mode,
	input  qspi_pgm_pkg::flash_vec_t active_mask,
	input  qspi_pgm_pkg::flash_vec_t flash_io1,
	output qspi_pgm_pkg::flash_vec_t flash_sck,
	output qspi_pgm_pkg::flash_vec_t flash_ncs,
	output qspi_pgm_pkg::flash_vec_t flash_io0,
	output logic                     readback
);
	import qspi_pgm_pkg::*;

	bit_count_t count_q;
	bit_count_t burst_limit;
	logic       burst_active;

	// Falling edge stage
	logic       active_q;
	logic       io0_q;

	// **************************************************************************
	// Burst bit counter
	// **************************************************************************

	always_ff @(posedge tck) begin
		if (!rst_n) begin
			count_q <= '0;
		end else if (cmd.load_opcode | cmd.sw_reset) begin
			count_q <= '0;
		end else if (cmd.push_opcode && sdr && count_q != '1) begin
			count_q <= count_q + 1'b1;
		end
	end

	// Eight bits per requested byte
	assign burst_limit = bit_count_t'(cmd.burst_len * `QPGM_BYTE_BITS);
	// First shift only drops the spare stage, so counts 1 to 8k carry the burst
	assign burst_active = cmd.push_opcode & sdr & (count_q != '0) &
		(count_q <= burst_limit);

	// **************************************************************************
	// Flash output stage
	// **************************************************************************

	// Updated half a cycle early so sck rises mid-bit
	always_ff @(negedge tck) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			io0_q <= 1'b0;
		end else begin
			active_q <= burst_active;
			io0_q <= burst_active ? opcode_bit : 1'b0;
		end
	end

	// Same chip select, clock and data on every device
	assign flash_ncs = {$bits(flash_vec_t){~active_q}};
	assign flash_sck = {$bits(flash_vec_t){tck & active_q}};
	assign flash_io0 = {$bits(flash_vec_t){io0_q}};

	// **************************************************************************
	// io1 readback
	// **************************************************************************

	always_comb begin
		logic sel_io1;
		// Lowest set mask bit wins, device 0 when none is set
		sel_io1 = flash_io1[0];
		for (int i = $bits(flash_vec_t) - 1; i >= 0; i--) begin
			if (active_mask[i]) begin
				sel_io1 = flash_io1[i];
			end
		end
		case (io1_mode)
			AND_ALL: readback = &flash_io1;
			OR_ALL:  readback = |flash_io1;
			default: readback = sel_io1;
		endcase
	end

endmodule

//--- design/qspi_pgm_config.svh
`ifndef QPGM_CONFIG_SVH
`define QPGM_CONFIG_SVH

// **************************************************************************
// Build options for the JTAG flash programming bridge
// **************************************************************************

// Flash devices driven in parallel, one of 1, 2, 4 or 8
`define QPGM_N_FLASH 4

// Width of the virtual instruction register
`define QPGM_IR_BITS 8

// Burst sizing
// Bits per opcode byte
`define QPGM_BYTE_BITS 8
// Opcode register length, six bytes plus one spare stage
`define QPGM_OPCODE_REG_BITS 49

// Vendor mode flag returned in the identity word
`define QPGM_TRIMODE 0

`endif

//--- design/qspi_pgm_pkg.sv
`include "qspi_pgm_config.svh"

package qspi_pgm_pkg;

	// Instruction word and per-device vectors
	typedef logic [`QPGM_IR_BITS-1:0] ir_t;
	typedef logic [`QPGM_N_FLASH-1:0] flash_vec_t;

	// Burst position, saturating at 63
	typedef logic [5:0] bit_count_t;
	// Opcode bytes per push, 1 to 6
	typedef logic [2:0] burst_len_t;

	// Virtual IR codes
	typedef enum ir_t {
		CONFIG       = ir_t'('h00),
		IO1_MODE     = ir_t'('h01),
		ACTIVE_FLASH = ir_t'('h11),
		SW_RESET     = ir_t'('h10),
		LOAD_OPCODE  = ir_t'('h02),
		PUSH1        = ir_t'('h03),
		PUSH2        = ir_t'('h13),
		PUSH3        = ir_t'('h04),
		PUSH4        = ir_t'('h14),
		PUSH5        = ir_t'('h05),
		PUSH6        = ir_t'('h15)
	} vir_op_e;

	// How io1 of the devices is folded onto tdo, code 3 behaves as SELECT
	typedef enum logic [1:0] {
		SELECT  = 2'd0,
		AND_ALL = 2'd1,
		OR_ALL  = 2'd2
	} io1_mode_e;

	// Decoded instruction
	typedef struct packed {
		logic       bypass;
		logic       set_io1_mode;
		logic       set_active;
		logic       load_opcode;
		logic       push_opcode;
		logic       sw_reset;
		burst_len_t burst_len;
	} vir_cmd_t;

endpackage

//--- design/qspi_pgm_top.sv
`timescale 1ns/10ps

module qspi_pgm_top (
	// JTAG hub side
	input  logic                     tck,
	input  logic                     rst_n,
	input  qspi_pgm_pkg::ir_t        ir_in,
	input  logic                     tdi,
	input  logic                     sdr,
	output logic                     tdo,
	output qspi_pgm_pkg::ir_t        ir_out,
	// Flash pins
	output qspi_pgm_pkg::flash_vec_t flash_sck,
	output qspi_pgm_pkg::flash_vec_t flash_ncs,
	output qspi_pgm_pkg::flash_vec_t flash_io0,
	input  qspi_pgm_pkg::flash_vec_t flash_io1,
	// Configuration and arbiter
	output logic                     enable_configuration,
	output logic                     flash_access_request,
	input  logic                     flash_access_granted
);
	import qspi_pgm_pkg::*;

	vir_cmd_t   cmd;
	logic       opcode_bit;
	io1_mode_e  io1_mode;
	flash_vec_t active_mask;
	logic       readback;

	vir_decode i_vir_decode (
		.ir_in                (ir_in),
		.flash_access_granted (flash_access_granted),
		.cmd                  (cmd),
		.ir_out               (ir_out),
		.enable_configuration (enable_configuration),
		.flash_access_request (flash_access_request)
	);

	scan_regs i_scan_regs (
		.tck         (tck),
		.rst_n       (rst_n),
		.tdi         (tdi),
		.sdr         (sdr),
		.cmd         (cmd),
		.readback    (readback),
		.opcode_bit  (opcode_bit),
		.io1_mode    (io1_mode),
		.active_mask (active_mask),
		.tdo         (tdo)
	);

	opcode_sequencer i_opcode_sequencer (
		.tck         (tck),
		.rst_n       (rst_n),
		.sdr         (sdr),
		.cmd         (cmd),
		.opcode_bit  (opcode_bit),
		.io1_mode    (io1_mode),
		.active_mask (active_mask),
		.flash_io1   (flash_io1),
		.flash_sck   (flash_sck),
		.flash_ncs   (flash_ncs),
		.flash_io0   (flash_io0),
		.readback    (readback)
	);

endmodule

//--- design/scan_regs.sv
`timescale 1ns/10ps
`include "qspi_pgm_config.svh"

module scan_regs (
	input  logic                     tck,
	input  logic                     rst_n,
	input  logic                     tdi,
	input  logic                     sdr,
	input  qspi_pgm_pkg::vir_cmd_t   cmd,
	input  logic                     readback,
	output logic                     opcode_bit,
	output qspi_pgm_pkg::io1_mode_e  io1_mode,
	output qspi_pgm_pkg::flash_vec_t active_mask,
	output logic                     tdo
);
	import qspi_pgm_pkg::*;

	localparam int unsigned OPCODE_BITS = `QPGM_OPCODE_REG_BITS;

	logic                   bypass_q;
	logic [1:0]             mode_q;
	flash_vec_t             mask_q;
	logic [OPCODE_BITS-1:0] opcode_q;

	// Shift enables, all qualified by sdr
	logic bypass_shift;
	logic mode_shift;
	logic mask_shift;
	logic opcode_shift;

	assign bypass_shift = cmd.bypass & sdr;
	assign mode_shift = cmd.set_io1_mode & sdr;
	assign mask_shift = cmd.set_active & sdr;
	// Loading fills the register, pushing drains it onto io0
	assign opcode_shift = (cmd.load_opcode | cmd.push_opcode) & sdr;

	// **************************************************************************
	// Bypass stage
	// **************************************************************************

	always_ff @(posedge tck) begin
		if (bypass_shift) begin
			bypass_q <= tdi;
		end
	end

	// **************************************************************************
	// Setup registers
	// **************************************************************************

	// Readback mode, cleared to SELECT
	always_ff @(posedge tck) begin
		if (!rst_n) begin
			mode_q <= SELECT;
		end else if (mode_shift) begin
			mode_q <= {tdi, mode_q[1]};
		end
	end

	// Active flash mask
	// Works down to a single device
	always_ff @(posedge tck) begin
		if (!rst_n) begin
			mask_q <= '0;
		end else if (mask_shift) begin
			mask_q <= flash_vec_t'({tdi, mask_q} >> 1);
		end
	end

	assign io1_mode = io1_mode_e'(mode_q);
	assign active_mask = mask_q;

	// **************************************************************************
	// Opcode and address register
	// **************************************************************************

	always_ff @(posedge tck) begin
		if (opcode_shift) begin
			opcode_q <= {tdi, opcode_q[OPCODE_BITS-1:1]};
		end
	end

	assign opcode_bit = opcode_q[0];

	// **************************************************************************
	// tdo select
	// **************************************************************************

	always_comb begin
		if (cmd.push_opcode) begin
			tdo = readback;
		end else if (cmd.set_io1_mode) begin
			tdo = mode_q[0];
		end else if (cmd.set_active) begin
			tdo = mask_q[0];
		end else if (cmd.load_opcode) begin
			tdo = opcode_q[0];
		end else begin
			tdo = bypass_q;
		end
	end

endmodule

//--- design/vir_decode.sv
`timescale 1ns/10ps
`include "qspi_pgm_config.svh"

module vir_decode (
	input  qspi_pgm_pkg::ir_t      ir_in,
	input  logic                   flash_access_granted,
	output qspi_pgm_pkg::vir_cmd_t cmd,
	output qspi_pgm_pkg::ir_t      ir_out,
	output logic                   enable_configuration,
	output logic                   flash_access_request
);
	import qspi_pgm_pkg::*;

	// Identity bit that encodes the device count
	localparam int unsigned FLASH_ID_BIT = $clog2(`QPGM_N_FLASH) + 1;

	// **************************************************************************
	// Instruction decode
	// **************************************************************************

	always_comb begin
		cmd = '0;
		case (ir_in)
			IO1_MODE:     cmd.set_io1_mode = 1'b1;
			ACTIVE_FLASH: cmd.set_active = 1'b1;
			LOAD_OPCODE:  cmd.load_opcode = 1'b1;
			PUSH1, PUSH2, PUSH3, PUSH4, PUSH5, PUSH6: begin
				cmd.push_opcode = 1'b1;
				case (ir_in)
					PUSH1:   cmd.burst_len = 3'd1;
					PUSH2:   cmd.burst_len = 3'd2;
					PUSH3:   cmd.burst_len = 3'd3;
					PUSH4:   cmd.burst_len = 3'd4;
					PUSH5:   cmd.burst_len = 3'd5;
					default: cmd.burst_len = 3'd6;
				endcase
			end
			// Reset still keeps the bypass path live
			SW_RESET: begin
				cmd.sw_reset = 1'b1;
				cmd.bypass = 1'b1;
			end
			default:      cmd.bypass = 1'b1;
		endcase
	end

	assign enable_configuration = (ir_in == CONFIG);

	// Any recognized code other than CONFIG needs the flash pins
	assign flash_access_request = cmd.set_io1_mode | cmd.set_active | cmd.load_opcode |
		cmd.push_opcode | cmd.sw_reset;

	// **************************************************************************
	// Identity word
	// **************************************************************************

	always_comb begin
		ir_out = '0;
		ir_out[`QPGM_IR_BITS-1] = flash_access_granted;
		ir_out[`QPGM_IR_BITS-2] = 1'(`QPGM_TRIMODE);
		ir_out[FLASH_ID_BIT] = 1'b1;
		// Version 1
		ir_out[0] = 1'b1;
	end

endmodule

//--- verification/qspi_pgm_assert.sv
`timescale 1ns/10ps

module qspi_pgm_assert (
	input logic                     tck,
	input logic                     rst_n,
	input qspi_pgm_pkg::flash_vec_t flash_sck,
	input qspi_pgm_pkg::flash_vec_t flash_ncs
);
	// All devices share one chip select
	ncs_equal: assert property (@(negedge tck) disable iff (!rst_n)
		((&flash_ncs) | ~(|flash_ncs)))
		else $error("flash_ncs bits differ: %h", flash_ncs);

	// Sampled on the falling edge, i.e. during the high phase of tck
	sck_idle: assert property (@(negedge tck) disable iff (!rst_n)
		(&flash_ncs) |-> (flash_sck == '0))
		else $error("flash_sck toggles while flash_ncs is high");

	// Chip select parked high while reset is held
	ncs_in_reset: assert property (@(negedge tck)
		(!rst_n && $past(!rst_n)) |-> (&flash_ncs))
		else $error("flash_ncs low during reset");

endmodule

bind qspi_pgm_top qspi_pgm_assert i_assert (
	.tck       (tck),
	.rst_n     (rst_n),
	.flash_sck (flash_sck),
	.flash_ncs (flash_ncs)
);

//--- verification/qspi_pgm_tb.sv
`timescale 1ns/10ps
`include "qspi_pgm_config.svh"

module qspi_pgm_tb;
	import qspi_pgm_pkg::*;

	localparam int N = `QPGM_N_FLASH;
	// Rough count of sdr cycles over all tests
	localparam int SHIFT_CYCLES = 16 + 2 * (4 + 2 * N) + 7 * 49 + 204 + 30
		+ 4 * (2 + 4 * (N + 16));
	localparam int TIMEOUT_CYCLES = 20 * SHIFT_CYCLES;

	logic       tck;
	logic       rst_n;
	ir_t        ir_in;
	logic       tdi;
	logic       sdr;
	logic       tdo;
	ir_t        ir_out;
	flash_vec_t flash_sck;
	flash_vec_t flash_ncs;
	flash_vec_t flash_io0;
	flash_vec_t flash_io1;
	logic       enable_configuration;
	logic       flash_access_request;
	logic       flash_access_granted;

	integer      seed = 32'h4520_accc;
	int          value_errors = 0;
	int          other_errors = 0;
	int          cycle_count = 0;
	int          pulse_count = 0;
	int          ncs_low_count = 0;
	logic        check_io0 = 1'b0;
	logic [48:0] load_bits;

	tb_clock i_tb_clock (
		.tck   (tck),
		.rst_n (rst_n)
	);

	qspi_pgm_top i_dut (
		.tck                  (tck),
		.rst_n                (rst_n),
		.ir_in                (ir_in),
		.tdi                  (tdi),
		.sdr                  (sdr),
		.tdo                  (tdo),
		.ir_out               (ir_out),
		.flash_sck            (flash_sck),
		.flash_ncs            (flash_ncs),
		.flash_io0            (flash_io0),
		.flash_io1            (flash_io1),
		.enable_configuration (enable_configuration),
		.flash_access_request (flash_access_request),
		.flash_access_granted (flash_access_granted)
	);

	// **************************************************************************
	// Reference model and compare tasks
	// **************************************************************************

	function automatic logic expected_readback(io1_mode_e mode, flash_vec_t mask,
		flash_vec_t io1);
		int idx;
		idx = 0;
		while (idx < N && !mask[idx]) idx++;
		// Empty mask falls back to device 0
		if (idx == N) idx = 0;
		if (mode == AND_ALL) return (io1 == {N{1'b1}});
		if (mode == OR_ALL) return (io1 != '0);
		return io1[idx];
	endfunction

	function automatic logic expected_request(ir_t code);
		case (code)
			IO1_MODE, ACTIVE_FLASH, SW_RESET, LOAD_OPCODE,
			PUSH1, PUSH2, PUSH3, PUSH4, PUSH5, PUSH6: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic ir_t expected_ir_out(logic granted);
		ir_t v;
		v = '0;
		v[7] = granted;
		v[6] = 1'(`QPGM_TRIMODE);
		v[$clog2(N) + 1] = 1'b1;
		v[0] = 1'b1;
		return v;
	endfunction

	function automatic vir_op_e push_op(int k);
		case (k)
			1: return PUSH1;
			2: return PUSH2;
			3: return PUSH3;
			4: return PUSH4;
			5: return PUSH5;
			default: return PUSH6;
		endcase
	endfunction

	task automatic compare_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic compare_ir(string name, ir_t got, ir_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic compare_flash(string name, flash_vec_t got, flash_vec_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	// **************************************************************************
	// Flash pin monitor and timeout
	// **************************************************************************

	always @(posedge tck) begin
		#1;
		if (rst_n) begin
			if (flash_ncs !== '1) begin
				ncs_low_count++;
			end
			if (&flash_sck) begin
				pulse_count++;
				// Bit 0 of the load sits in the spare stage
				if (check_io0 && pulse_count < 49) begin
					compare_flash("flash_io0", flash_io0, {N{load_bits[pulse_count]}});
				end
			end
		end
	end

	always @(posedge tck) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// **************************************************************************
	// Stimulus
	// **************************************************************************

	task automatic select_op(ir_t op);
		@(negedge tck);
		ir_in <= op;
		sdr <= 1'b0;
	endtask

	task automatic shift_bits(logic [63:0] data, int n, output logic [63:0] seen);
		seen = '0;
		for (int i = 0; i < n; i++) begin
			@(negedge tck);
			tdi <= data[i];
			sdr <= 1'b1;
			@(posedge tck);
			seen[i] = tdo;
		end
		@(negedge tck);
		sdr <= 1'b0;
	endtask

	// Each byte gives eight sck pulses framed by a low chip select
	task automatic push_burst(int k, logic with_io0);
		select_op(push_op(k));
		pulse_count = 0;
		ncs_low_count = 0;
		check_io0 = with_io0;
		repeat (8 * k + 4) begin
			@(negedge tck);
			sdr <= 1'b1;
		end
		@(negedge tck);
		sdr <= 1'b0;
		repeat (3) @(negedge tck);
		if (pulse_count != 8 * k) begin
			$display("Wrong number of sck pulses for a %0d byte push: %0d seen", k,
				pulse_count);
			other_errors++;
		end
		if (ncs_low_count != 8 * k) begin
			$display("Chip select low for %0d cycles in a %0d byte push", ncs_low_count,
				k);
			other_errors++;
		end
		check_io0 = 1'b0;
	endtask

	initial begin
		logic [63:0] data;
		logic [63:0] seen;
		logic [63:0] seen2;
		ir_t         codes[13];
		flash_vec_t  mask;

		ir_in = CONFIG;
		tdi = 1'b0;
		sdr = 1'b0;
		flash_io1 = '0;
		flash_access_granted = 1'b0;
		wait (rst_n === 1'b1);
		@(negedge tck);

		// Reset state and decode
		compare_flash("flash_ncs", flash_ncs, '1);
		compare_flash("flash_sck", flash_sck, '0);
		compare_flash("flash_io0", flash_io0, '0);
		codes = '{CONFIG, IO1_MODE, ACTIVE_FLASH, SW_RESET, LOAD_OPCODE, PUSH1, PUSH2,
			PUSH3, PUSH4, PUSH5, PUSH6, 8'h22, 8'hff};
		foreach (codes[i]) begin
			@(negedge tck);
			ir_in <= codes[i];
			@(posedge tck);
			compare_bit("flash_access_request", flash_access_request,
				expected_request(codes[i]));
			compare_bit("enable_configuration", enable_configuration, codes[i] == CONFIG);
		end
		for (int g = 0; g < 2; g++) begin
			@(negedge tck);
			flash_access_granted <= g[0];
			@(posedge tck);
			compare_ir("ir_out", ir_out, expected_ir_out(g[0]));
		end

		// Bypass
		select_op(CONFIG);
		data = {$random(seed), $random(seed)};
		shift_bits(data, 16, seen);
		compare_bit("enable_configuration", enable_configuration, 1'b1);
		for (int i = 1; i < 16; i++) compare_bit("tdo", seen[i], data[i - 1]);

		// Setup registers read back LSB first
		select_op(IO1_MODE);
		data = 64'h2;
		shift_bits(data, 2, seen);
		shift_bits(64'h1, 2, seen);
		for (int i = 0; i < 2; i++) compare_bit("tdo", seen[i], data[i]);
		select_op(ACTIVE_FLASH);
		data = {$random(seed), $random(seed)};
		shift_bits(data, N, seen);
		shift_bits(~data, N, seen2);
		for (int i = 0; i < N; i++) compare_bit("tdo", seen2[i], data[i]);

		// Burst framing, one fresh load per push
		for (int k = 1; k <= 6; k++) begin
			select_op(LOAD_OPCODE);
			data = {$random(seed), $random(seed)};
			load_bits = data[48:0];
			shift_bits(data, 49, seen);
			push_burst(k, 1'b1);
		end

		// Count restarts after SW_RESET without a new load
		select_op(SW_RESET);
		push_burst(3, 1'b0);

		// Readback in every mode code
		for (int m = 0; m < 4; m++) begin
			select_op(IO1_MODE);
			shift_bits(64'(m), 2, seen);
			for (int r = 0; r < 4; r++) begin
				select_op(ACTIVE_FLASH);
				mask = flash_vec_t'($random(seed));
				shift_bits(64'(mask), N, seen);
				select_op(PUSH6);
				repeat (16) begin
					@(negedge tck);
					sdr <= 1'b1;
					flash_io1 <= flash_vec_t'($random(seed));
					@(posedge tck);
					compare_bit("tdo", tdo, expected_readback(io1_mode_e'(m), mask,
						flash_io1));
				end
				@(negedge tck);
				sdr <= 1'b0;
			end
		end

		repeat (4) @(negedge tck);
		$display("Checks done: %0d value errors, %0d other errors", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
	output logic tck,
	output logic rst_n
);
	// 10 ns period
	initial begin
		tck = 1'b0;
		forever #5 tck = ~tck;
	end

	// Reset held for 10 cycles, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge tck);
		@(negedge tck);
		rst_n <= 1'b1;
	end

endmodule
